//--- ahb_pkg.sv
package ahb_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // sram depth in 32-bit words
    localparam int MEM_WORDS = 256;

    // wrap4 stays inside one 16-byte block
    localparam logic [ADDR_W-1:0] WRAP4_MASK = 32'hFFFF_FFF0;
    localparam int BEATS4 = 4;

    // hburst encoding
    typedef enum logic [2:0] {
        SINGLE = 3'd0,
        WRAP4  = 3'd2,
        INCR4  = 3'd3
    } burst_type_e;

    // htrans encoding
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        BUSY   = 2'd1,
        NONSEQ = 2'd2,
        SEQ    = 2'd3
    } trans_type_e;

    // burst master FSM
    typedef enum logic [1:0] {
        M_IDLE,
        M_REQ,
        M_BURST,
        M_LAST
    } master_state_e;

endpackage

//--- ahb_bus_if.sv
`timescale 1ns/1ns

interface ahb_bus_if;

    // master side of the address and data phase
    logic [ahb_pkg::ADDR_W-1:0] haddr;
    ahb_pkg::trans_type_e       htrans;
    logic                       hwrite;
    ahb_pkg::burst_type_e       hburst;
    logic [ahb_pkg::DATA_W-1:0] hwdata;
    logic                       hbusreq;

    // back from the arbiter
    logic                       hgrant;
    logic                       hready;
    logic [ahb_pkg::DATA_W-1:0] hrdata;

    modport master (
        output haddr,
        output htrans,
        output hwrite,
        output hburst,
        output hwdata,
        output hbusreq,
        input  hgrant,
        input  hready,
        input  hrdata
    );

    modport arbiter (
        input  haddr,
        input  htrans,
        input  hwrite,
        input  hburst,
        input  hwdata,
        input  hbusreq,
        output hgrant,
        output hready,
        output hrdata
    );

endinterface

//--- ahb_burst_master.sv
`timescale 1ns/1ns

module ahb_burst_master (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       cmd_valid,
    output logic                       cmd_ready,
    input  logic [ahb_pkg::ADDR_W-1:0] cmd_addr,
    input  logic                       cmd_write,
    input  ahb_pkg::burst_type_e       cmd_burst,
    input  logic                       wr_valid,
    output logic                       wr_ready,
    input  logic [ahb_pkg::DATA_W-1:0] wr_data,
    output logic                       rsp_valid,
    output logic [ahb_pkg::DATA_W-1:0] rsp_data,
    ahb_bus_if.master                  bus
);

    ahb_pkg::master_state_e     state;
    ahb_pkg::burst_type_e       burst_q;
    logic                       write_q;
    logic [ahb_pkg::ADDR_W-1:0] addr_q;
    logic [ahb_pkg::ADDR_W-1:0] addr_nxt;
    logic [ahb_pkg::DATA_W-1:0] wdata_q;
    logic [1:0]                 beat_cnt;
    logic                       beat_ok;
    logic                       addr_acc;
    logic                       dp_read;

    // reads never wait, writes need their beat first
    assign beat_ok = !write_q || wr_valid;

    always_comb begin
        bus.htrans = ahb_pkg::IDLE;
        case (state)
            ahb_pkg::M_REQ: begin
                if (bus.hgrant && beat_ok) begin
                    bus.htrans = ahb_pkg::NONSEQ;
                end
            end
            // missing write beat turns into BUSY, address held
            ahb_pkg::M_BURST: begin
                bus.htrans = beat_ok ? ahb_pkg::SEQ : ahb_pkg::BUSY;
            end
            default: begin
                bus.htrans = ahb_pkg::IDLE;
            end
        endcase
    end

    assign addr_acc = bus.hready &&
                      (bus.htrans == ahb_pkg::NONSEQ || bus.htrans == ahb_pkg::SEQ);

    // wrap4 steps the offset inside the 16-byte block
    always_comb begin
        if (burst_q == ahb_pkg::WRAP4) begin
            addr_nxt = (addr_q & ahb_pkg::WRAP4_MASK) |
                       ((addr_q + ahb_pkg::ADDR_W'(4)) & ~ahb_pkg::WRAP4_MASK);
        end else begin
            addr_nxt = addr_q + ahb_pkg::ADDR_W'(4);
        end
    end

    assign cmd_ready = (state == ahb_pkg::M_IDLE);
    assign wr_ready  = write_q && bus.hgrant && bus.hready &&
                       (state == ahb_pkg::M_REQ || state == ahb_pkg::M_BURST);

    // keep asking through the last data phase so a follow-up burst keeps the grant
    assign bus.hbusreq = (state != ahb_pkg::M_IDLE) || cmd_valid;
    assign bus.haddr   = addr_q;
    assign bus.hwrite  = write_q;
    assign bus.hburst  = burst_q;
    assign bus.hwdata  = wdata_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= ahb_pkg::M_IDLE;
            burst_q   <= ahb_pkg::SINGLE;
            write_q   <= 1'b0;
            beat_cnt  <= '0;
            dp_read   <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            if (bus.hready) begin
                dp_read <= addr_acc && !write_q;
            end
            rsp_valid <= dp_read && bus.hready;
            case (state)
                ahb_pkg::M_IDLE: begin
                    if (cmd_valid) begin
                        write_q <= cmd_write;
                        burst_q <= cmd_burst;
                        state   <= ahb_pkg::M_REQ;
                    end
                end
                ahb_pkg::M_REQ: begin
                    if (addr_acc) begin
                        beat_cnt <= 2'd1;
                        if (burst_q == ahb_pkg::SINGLE) begin
                            state <= ahb_pkg::M_LAST;
                        end else begin
                            state <= ahb_pkg::M_BURST;
                        end
                    end
                end
                ahb_pkg::M_BURST: begin
                    if (addr_acc) begin
                        beat_cnt <= beat_cnt + 2'd1;
                        if (beat_cnt == 2'(ahb_pkg::BEATS4 - 1)) begin
                            state <= ahb_pkg::M_LAST;
                        end
                    end
                end
                // waiting for the final data phase
                ahb_pkg::M_LAST: begin
                    if (bus.hready) begin
                        state <= ahb_pkg::M_IDLE;
                    end
                end
                default: begin
                    state <= ahb_pkg::M_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            addr_q <= cmd_addr;
        end else if (addr_acc) begin
            addr_q <= addr_nxt;
        end
        if (wr_valid && wr_ready) begin
            wdata_q <= wr_data;
        end
        if (dp_read && bus.hready) begin
            rsp_data <= bus.hrdata;
        end
    end

endmodule

//--- ahb_arbiter.sv
`timescale 1ns/1ns

module ahb_arbiter (
    input  logic                       clk,
    input  logic                       rstn,
    ahb_bus_if.arbiter                 m0,
    ahb_bus_if.arbiter                 m1,
    output logic [ahb_pkg::ADDR_W-1:0] haddr,
    output ahb_pkg::trans_type_e       htrans,
    output logic                       hwrite,
    output ahb_pkg::burst_type_e       hburst,
    output logic [ahb_pkg::DATA_W-1:0] hwdata,
    input  logic                       hready,
    input  logic [ahb_pkg::DATA_W-1:0] hrdata
);

    logic                 owner;
    logic                 gnt_vld;
    logic                 rr_prio;
    logic                 dp_owner;
    logic                 owner_req;
    logic                 handover;
    ahb_pkg::trans_type_e owner_trans;

    assign owner_trans = owner ? m1.htrans : m0.htrans;
    assign owner_req   = gnt_vld && (owner ? m1.hbusreq : m0.hbusreq);

    // only between bursts: owner idle and previous data phase done
    assign handover = hready && (!gnt_vld || owner_trans == ahb_pkg::IDLE);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            owner    <= 1'b0;
            gnt_vld  <= 1'b1;
            rr_prio  <= 1'b1;
            dp_owner <= 1'b0;
        end else begin
            if (hready) begin
                dp_owner <= owner;
            end
            if (handover && !owner_req) begin
                if (m0.hbusreq && m1.hbusreq) begin
                    owner   <= rr_prio;
                    rr_prio <= !rr_prio;
                    gnt_vld <= 1'b1;
                end else if (m0.hbusreq || m1.hbusreq) begin
                    owner   <= m1.hbusreq;
                    rr_prio <= !m1.hbusreq;
                    gnt_vld <= 1'b1;
                end else begin
                    gnt_vld <= 1'b0;
                end
            end
        end
    end

    assign m0.hgrant = gnt_vld && !owner;
    assign m1.hgrant = gnt_vld && owner;

    // address phase from the granted master
    assign haddr  = owner ? m1.haddr : m0.haddr;
    assign hwrite = owner ? m1.hwrite : m0.hwrite;
    assign hburst = owner ? m1.hburst : m0.hburst;
    assign htrans = gnt_vld ? owner_trans : ahb_pkg::IDLE;

    // write data follows whoever owns the data phase
    assign hwdata = dp_owner ? m1.hwdata : m0.hwdata;

    assign m0.hready = hready;
    assign m1.hready = hready;
    assign m0.hrdata = hrdata;
    assign m1.hrdata = hrdata;

endmodule

//--- ahb_sram_slave.sv
`timescale 1ns/1ns

module ahb_sram_slave (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [ahb_pkg::ADDR_W-1:0] haddr,
    input  ahb_pkg::trans_type_e       htrans,
    input  logic                       hwrite,
    input  ahb_pkg::burst_type_e       hburst,
    input  logic [ahb_pkg::DATA_W-1:0] hwdata,
    output logic                       hready,
    output logic [ahb_pkg::DATA_W-1:0] hrdata
);

    logic [ahb_pkg::DATA_W-1:0]              mem [ahb_pkg::MEM_WORDS];
    logic [$clog2(ahb_pkg::MEM_WORDS)-1:0] dp_idx;
    logic [$clog2(ahb_pkg::MEM_WORDS)-1:0] addr_idx;
    logic                                  dp_valid;
    logic                                  dp_write;
    logic                                  wait_q;
    logic                                  addr_acc;

    assign addr_acc = hready &&
                      (htrans == ahb_pkg::NONSEQ || htrans == ahb_pkg::SEQ);

    // word index from the address phase, higher bits ignored
    assign addr_idx = haddr[$clog2(ahb_pkg::MEM_WORDS)+1:2];

    assign hready = !wait_q;
    assign hrdata = mem[dp_idx];

    // one wait state on every nonseq data phase
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dp_valid <= 1'b0;
            dp_write <= 1'b0;
            wait_q   <= 1'b0;
        end else if (hready) begin
            dp_valid <= addr_acc;
            dp_write <= hwrite;
            wait_q   <= (htrans == ahb_pkg::NONSEQ);
        end else begin
            wait_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (addr_acc) begin
            dp_idx <= addr_idx;
        end
        if (hready && dp_valid && dp_write) begin
            mem[dp_idx] <= hwdata;
        end
    end

endmodule

//--- ahb_subsystem_top.sv
`timescale 1ns/1ns

module ahb_subsystem_top (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       cmd_valid_0,
    output logic                       cmd_ready_0,
    input  logic [ahb_pkg::ADDR_W-1:0] cmd_addr_0,
    input  logic                       cmd_write_0,
    input  ahb_pkg::burst_type_e       cmd_burst_0,
    input  logic                       wr_valid_0,
    output logic                       wr_ready_0,
    input  logic [ahb_pkg::DATA_W-1:0] wr_data_0,
    output logic                       rsp_valid_0,
    output logic [ahb_pkg::DATA_W-1:0] rsp_data_0,
    input  logic                       cmd_valid_1,
    output logic                       cmd_ready_1,
    input  logic [ahb_pkg::ADDR_W-1:0] cmd_addr_1,
    input  logic                       cmd_write_1,
    input  ahb_pkg::burst_type_e       cmd_burst_1,
    input  logic                       wr_valid_1,
    output logic                       wr_ready_1,
    input  logic [ahb_pkg::DATA_W-1:0] wr_data_1,
    output logic                       rsp_valid_1,
    output logic [ahb_pkg::DATA_W-1:0] rsp_data_1
);

    // shared bus between arbiter and sram
    logic [ahb_pkg::ADDR_W-1:0] haddr;
    ahb_pkg::trans_type_e       htrans;
    logic                       hwrite;
    ahb_pkg::burst_type_e       hburst;
    logic [ahb_pkg::DATA_W-1:0] hwdata;
    logic                       hready;
    logic [ahb_pkg::DATA_W-1:0] hrdata;

    ahb_bus_if bus_0 ();
    ahb_bus_if bus_1 ();

    ahb_burst_master u_master_0 (
        .clk       (clk),
        .rstn      (rstn),
        .cmd_valid (cmd_valid_0),
        .cmd_ready (cmd_ready_0),
        .cmd_addr  (cmd_addr_0),
        .cmd_write (cmd_write_0),
        .cmd_burst (cmd_burst_0),
        .wr_valid  (wr_valid_0),
        .wr_ready  (wr_ready_0),
        .wr_data   (wr_data_0),
        .rsp_valid (rsp_valid_0),
        .rsp_data  (rsp_data_0),
        .bus       (bus_0.master)
    );

    ahb_burst_master u_master_1 (
        .clk       (clk),
        .rstn      (rstn),
        .cmd_valid (cmd_valid_1),
        .cmd_ready (cmd_ready_1),
        .cmd_addr  (cmd_addr_1),
        .cmd_write (cmd_write_1),
        .cmd_burst (cmd_burst_1),
        .wr_valid  (wr_valid_1),
        .wr_ready  (wr_ready_1),
        .wr_data   (wr_data_1),
        .rsp_valid (rsp_valid_1),
        .rsp_data  (rsp_data_1),
        .bus       (bus_1.master)
    );

    ahb_arbiter u_arbiter (
        .clk    (clk),
        .rstn   (rstn),
        .m0     (bus_0.arbiter),
        .m1     (bus_1.arbiter),
        .haddr  (haddr),
        .htrans (htrans),
        .hwrite (hwrite),
        .hburst (hburst),
        .hwdata (hwdata),
        .hready (hready),
        .hrdata (hrdata)
    );

    ahb_sram_slave u_sram (
        .clk    (clk),
        .rstn   (rstn),
        .haddr  (haddr),
        .htrans (htrans),
        .hwrite (hwrite),
        .hburst (hburst),
        .hwdata (hwdata),
        .hready (hready),
        .hrdata (hrdata)
    );

endmodule

//--- tb_ahb_model.svh
`ifndef TB_AHB_MODEL_SVH
`define TB_AHB_MODEL_SVH

// word model of the sram, indexed by address bits 9:2
logic [31:0] model_mem [256];
int          checks;
int          errors;

// address of beat n of a burst
function automatic logic [31:0] beat_addr(input logic [31:0] base,
                                          input ahb_pkg::burst_type_e burst,
                                          input int n);
    logic [31:0] step;
    step = base + 32'(4 * n);
    case (burst)
        ahb_pkg::SINGLE: begin
            beat_addr = base;
        end
        // offset wraps inside the 16-byte block
        ahb_pkg::WRAP4: begin
            beat_addr = (base & 32'hFFFF_FFF0) | (step & 32'h0000_000F);
        end
        default: begin
            beat_addr = step;
        end
    endcase
endfunction

function automatic int word_idx(input logic [31:0] addr);
    return int'(addr[9:2]);
endfunction

task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_empty(input string name, input int left);
    checks++;
    if (left != 0) begin
        errors++;
        $display("%s: %0d read responses never arrived", name, left);
    end
endtask

`endif

//--- tb_ahb_subsystem.sv
`timescale 1ns/1ns

module tb_ahb_subsystem;

    localparam int MAX_CYCLES = 4000;

    logic                 clk;
    logic                 rstn;
    logic                 cmd_valid [2];
    logic                 cmd_ready [2];
    logic [31:0]          cmd_addr [2];
    logic                 cmd_write [2];
    ahb_pkg::burst_type_e cmd_burst [2];
    logic                 wr_valid [2];
    logic                 wr_ready [2];
    logic [31:0]          wr_data [2];
    logic                 rsp_valid [2];
    logic [31:0]          rsp_data [2];

    integer      seed;
    int          cycles;
    int          tests_run;
    int          tests_failed;
    int          err_start;
    string       test_name;
    logic [31:0] exp_q0 [$];
    logic [31:0] exp_q1 [$];

    `include "tb_ahb_model.svh"

    ahb_subsystem_top uut (
        .clk         (clk),
        .rstn        (rstn),
        .cmd_valid_0 (cmd_valid[0]),
        .cmd_ready_0 (cmd_ready[0]),
        .cmd_addr_0  (cmd_addr[0]),
        .cmd_write_0 (cmd_write[0]),
        .cmd_burst_0 (cmd_burst[0]),
        .wr_valid_0  (wr_valid[0]),
        .wr_ready_0  (wr_ready[0]),
        .wr_data_0   (wr_data[0]),
        .rsp_valid_0 (rsp_valid[0]),
        .rsp_data_0  (rsp_data[0]),
        .cmd_valid_1 (cmd_valid[1]),
        .cmd_ready_1 (cmd_ready[1]),
        .cmd_addr_1  (cmd_addr[1]),
        .cmd_write_1 (cmd_write[1]),
        .cmd_burst_1 (cmd_burst[1]),
        .wr_valid_1  (wr_valid[1]),
        .wr_ready_1  (wr_ready[1]),
        .wr_data_1   (wr_data[1]),
        .rsp_valid_1 (rsp_valid[1]),
        .rsp_data_1  (rsp_data[1])
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    // read responses must come back in burst order per master
    always @(negedge clk) begin
        if (rstn && rsp_valid[0]) begin
            if (exp_q0.size() == 0) begin
                errors++;
                $display("%s: master 0 returned read data nobody asked for", test_name);
            end else begin
                check({test_name, " m0 read"}, exp_q0.pop_front(), rsp_data[0]);
            end
        end
        if (rstn && rsp_valid[1]) begin
            if (exp_q1.size() == 0) begin
                errors++;
                $display("%s: master 1 returned read data nobody asked for", test_name);
            end else begin
                check({test_name, " m1 read"}, exp_q1.pop_front(), rsp_data[1]);
            end
        end
    end

    // one command with its write beats; gap is the percent chance of a missing beat
    task automatic do_burst(input int m, input logic [31:0] addr, input logic wr,
                            input ahb_pkg::burst_type_e burst, input int gap);
        logic [31:0] data [4];
        logic [31:0] a;
        int          n;
        int          i;
        n = (burst == ahb_pkg::SINGLE) ? 1 : 4;
        for (i = 0; i < n; i++) begin
            data[i] = $random(seed);
        end
        @(negedge clk);
        cmd_valid[m] = 1'b1;
        cmd_addr[m]  = addr;
        cmd_write[m] = wr;
        cmd_burst[m] = burst;
        while (!cmd_ready[m]) begin
            @(negedge clk);
        end
        // accepted on the coming rising edge
        for (i = 0; i < n; i++) begin
            a = beat_addr(addr, burst, i);
            if (wr) begin
                model_mem[word_idx(a)] = data[i];
            end else if (m == 0) begin
                exp_q0.push_back(model_mem[word_idx(a)]);
            end else begin
                exp_q1.push_back(model_mem[word_idx(a)]);
            end
        end
        @(negedge clk);
        cmd_valid[m] = 1'b0;
        i = 0;
        while (wr && i < n) begin
            if ($unsigned($random(seed)) % 100 < gap) begin
                wr_valid[m] = 1'b0;
            end else begin
                wr_valid[m] = 1'b1;
                wr_data[m]  = data[i];
            end
            if (wr_valid[m] && wr_ready[m]) begin
                i++;
            end
            @(negedge clk);
        end
        wr_valid[m] = 1'b0;
        while (!cmd_ready[m]) begin
            @(negedge clk);
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while ((exp_q0.size() != 0 || exp_q1.size() != 0) && n < 20) begin
            @(negedge clk);
            n++;
        end
        check_empty(test_name, exp_q0.size() + exp_q1.size());
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_start = errors;
    endtask

    task automatic end_test();
        drain();
        tests_run++;
        if (errors == err_start) begin
            $display("test %0d %s: passed", tests_run, test_name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, test_name, errors - err_start);
        end
    endtask

    // fill the 64-byte region first, then random commands inside it
    task automatic random_traffic(input int m, input logic [31:0] base, input int count);
        logic [31:0]          off;
        ahb_pkg::burst_type_e b;
        int                   k;
        int                   r;
        for (k = 0; k < 4; k++) begin
            do_burst(m, base + 32'(16 * k), 1'b1, ahb_pkg::INCR4, 20);
        end
        for (k = 0; k < count; k++) begin
            r = $unsigned($random(seed)) % 3;
            b = (r == 0) ? ahb_pkg::SINGLE : (r == 1) ? ahb_pkg::INCR4 : ahb_pkg::WRAP4;
            off = (b == ahb_pkg::INCR4) ? 32'(($unsigned($random(seed)) % 13) * 4)
                                        : 32'(($unsigned($random(seed)) % 16) * 4);
            do_burst(m, base + off, $random(seed) & 1, b, 25);
        end
    endtask

    initial begin
        int m;
        int k;
        seed         = 47451;
        cycles       = 0;
        checks       = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "reset";
        rstn         = 1'b0;
        for (m = 0; m < 2; m++) begin
            cmd_valid[m] = 1'b0;
            cmd_addr[m]  = '0;
            cmd_write[m] = 1'b0;
            cmd_burst[m] = ahb_pkg::SINGLE;
            wr_valid[m]  = 1'b0;
            wr_data[m]   = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);

        start_test("reset_state");
        for (m = 0; m < 2; m++) begin
            check("reset cmd_ready", 32'd1, 32'(cmd_ready[m]));
            check("reset wr_ready", 32'd0, 32'(wr_ready[m]));
            check("reset rsp_valid", 32'd0, 32'(rsp_valid[m]));
        end
        end_test();

        start_test("single_rw");
        for (m = 0; m < 2; m++) begin
            for (k = 0; k < 4; k++) begin
                do_burst(m, 32'h000 + 32'(m * 256 + k * 4), 1'b1, ahb_pkg::SINGLE, 0);
            end
            for (k = 0; k < 4; k++) begin
                do_burst(m, 32'h000 + 32'(m * 256 + k * 4), 1'b0, ahb_pkg::SINGLE, 0);
            end
        end
        end_test();

        start_test("incr4_rw");
        do_burst(0, 32'h040, 1'b1, ahb_pkg::INCR4, 0);
        for (k = 0; k < 4; k++) begin
            do_burst(0, 32'h040 + 32'(4 * k), 1'b0, ahb_pkg::SINGLE, 0);
        end
        end_test();

        start_test("wrap4_rw");
        do_burst(1, 32'h128, 1'b1, ahb_pkg::WRAP4, 0);
        do_burst(1, 32'h128, 1'b0, ahb_pkg::WRAP4, 0);
        // beats land at offsets 8, c, 0, 4
        for (k = 0; k < 4; k++) begin
            do_burst(1, 32'h120 + 32'(4 * k), 1'b0, ahb_pkg::SINGLE, 0);
        end
        end_test();

        start_test("busy_gaps");
        for (m = 0; m < 2; m++) begin
            do_burst(m, 32'h080 + 32'(m * 256), 1'b1, ahb_pkg::INCR4, 50);
            do_burst(m, 32'h098 + 32'(m * 256), 1'b1, ahb_pkg::WRAP4, 50);
            for (k = 0; k < 8; k++) begin
                do_burst(m, 32'h080 + 32'(m * 256 + k * 4), 1'b0, ahb_pkg::SINGLE, 0);
            end
        end
        end_test();

        start_test("concurrent");
        fork
            random_traffic(0, 32'h200, 12);
            random_traffic(1, 32'h300, 12);
        join
        end_test();

        $display("tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+.
ahb_pkg.sv
ahb_bus_if.sv
ahb_burst_master.sv
ahb_arbiter.sv
ahb_sram_slave.sv
ahb_subsystem_top.sv
tb_ahb_subsystem.sv
